/* sim/ooo_tests.txt */
// columns: opcode rd rs1 rs2 immediate expected_value, all hex
// opcodes: 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 addi, ff ends the list
// all six opcodes
05 01 00 00 12345678 12345678
05 02 00 00 0f0f00ff 0f0f00ff
00 03 01 02 00000000 21435777
01 04 01 02 00000000 03255579
02 05 01 02 00000000 02040078
03 06 01 02 00000000 1f3f56ff
04 07 01 02 00000000 1d3b5687
// back to back dependent chain
05 08 00 00 00000005 00000005
00 08 08 08 00000000 0000000a
01 09 08 01 00000000 edcba992
04 0a 09 08 00000000 edcba998
03 0b 0a 03 00000000 edcbffff
02 0c 0b 06 00000000 0d0b56ff
// writes to x0 show on the port, x0 still reads zero
05 00 01 00 00000100 12345778
00 00 02 03 00000000 30525876
00 0d 00 05 00000000 02040078
05 0e 00 00 00000007 00000007
// two writers of x15, readers see the younger one
05 0f 00 00 00000111 00000111
05 0f 00 00 00000222 00000222
00 10 0f 0f 00000000 00000444
05 0f 0f 00 00000001 00000223
01 11 0f 10 00000000 fffffddf
// burst longer than the rob
05 12 00 00 00000001 00000001
05 13 00 00 00000002 00000002
05 14 00 00 00000003 00000003
05 15 00 00 00000004 00000004
05 16 00 00 00000005 00000005
00 17 12 13 00000000 00000003
04 18 14 15 00000000 00000007
03 19 16 17 00000000 00000007
01 1a 19 18 00000000 00000000
02 1b 01 07 00000000 10305600
ff 00 00 00 00000000 00000000

/* tb.f */
design/ooo_pkg.sv
design/regfile_scoreboard.sv
design/reorder_buffer.sv
design/dispatch_unit.sv
design/int_alu.sv
design/ooo_backend_top.sv
sim/ooo_backend_properties.sv
sim/tb_ooo_backend.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_ooo_backend -f tb.f

./obj_dir/Vtb_ooo_backend +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "^TESTBENCH PASSED$" sim.log; then
  exit 0
fi
exit 1

/* sim/tb_ooo_backend.sv */
module tb_ooo_backend;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int rob_tag_w     = 2;
  localparam int max_tests     = 64;
  localparam int ready_timeout = 200;
  localparam int drain_timeout = 500;

  logic                           clk;
  logic                           rst;
  logic                           in_valid;
  logic                           in_ready;
  ooo_pkg::alu_op_e               in_op;
  logic [ooo_pkg::reg_addr_w-1:0] in_rd;
  logic [ooo_pkg::reg_addr_w-1:0] in_rs1;
  logic [ooo_pkg::reg_addr_w-1:0] in_rs2;
  logic [ooo_pkg::xlen-1:0]       in_imm;
  logic                           commit_valid;
  logic [ooo_pkg::reg_addr_w-1:0] commit_rd;
  logic [ooo_pkg::xlen-1:0]       commit_value;
  logic [rob_tag_w-1:0]           commit_tag;

  // six words per instruction: op, rd, rs1, rs2, imm, expected value
  logic [31:0] test_mem [max_tests*6];

  int   seed           = 32'h228438c9;
  int   num_tests      = 0;
  int   commit_count   = 0;
  int   mismatch_count = 0;
  int   timeout_count  = 0;
  int   extra_count    = 0;
  int   load_errors    = 0;
  logic timed_out      = 1'b0;

  ooo_backend_top #(.rob_tag_w(rob_tag_w)) UUT (
    .clk, .rst,
    .in_valid, .in_ready, .in_op, .in_rd, .in_rs1, .in_rs2, .in_imm,
    .commit_valid, .commit_rd, .commit_value, .commit_tag
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // list ends at the first line whose opcode word is ff
  task automatic count_tests();
    num_tests = 0;
    while (num_tests < max_tests && test_mem[num_tests * 6] != 32'hff) begin
      num_tests++;
    end
    if (num_tests == max_tests || num_tests == 0) begin
      $display("Error: test file has no end marker or no instructions");
      load_errors++;
      num_tests = 0;
    end
  endtask

  task automatic insert_gap();
    int len;
    if (($unsigned($random(seed)) % 4) == 0) begin
      len = 1 + ($unsigned($random(seed)) % 3);
      in_valid <= 1'b0;
      repeat (len) @(posedge clk);
    end
  endtask

  // present one line and hold it until the DUT takes it
  task automatic present_line(input int idx);
    int base;
    int wait_count;
    base       = idx * 6;
    wait_count = 0;
    in_valid <= 1'b1;
    in_op    <= ooo_pkg::alu_op_e'(test_mem[base][2:0]);
    in_rd    <= test_mem[base + 1][ooo_pkg::reg_addr_w-1:0];
    in_rs1   <= test_mem[base + 2][ooo_pkg::reg_addr_w-1:0];
    in_rs2   <= test_mem[base + 3][ooo_pkg::reg_addr_w-1:0];
    in_imm   <= test_mem[base + 4];
    @(negedge clk);
    while (!in_ready && wait_count < ready_timeout) begin
      wait_count++;
      @(negedge clk);
    end
    if (in_ready) begin
      @(posedge clk);
    end else begin
      $display("Timeout at %0t: in_ready stayed low for instruction %0d", $time, idx);
      timeout_count++;
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_for_commits();
    int wait_count;
    wait_count = 0;
    while (commit_count < num_tests && wait_count < drain_timeout) begin
      wait_count++;
      @(posedge clk);
    end
    if (commit_count < num_tests) begin
      $display("Timeout at %0t: only %0d of %0d instructions committed",
               $time, commit_count, num_tests);
      timeout_count++;
    end
  endtask

  // commits must come back in file order
  always @(negedge clk) begin
    if (!rst && commit_valid) begin
      if (commit_count >= num_tests) begin
        $display("Error at %0t: commit to rd %0d after the last instruction", $time, commit_rd);
        extra_count++;
      end else begin
        if (commit_rd != test_mem[commit_count * 6 + 1][ooo_pkg::reg_addr_w-1:0]) begin
          $display("Mismatch at %0t: commit %0d wrote rd %0d, expected rd %0d", $time,
                   commit_count, commit_rd, test_mem[commit_count * 6 + 1]);
          mismatch_count++;
        end
        if (commit_value != test_mem[commit_count * 6 + 5]) begin
          $display("Mismatch at %0t: commit %0d value %h, expected %h", $time,
                   commit_count, commit_value, test_mem[commit_count * 6 + 5]);
          mismatch_count++;
        end
        // rob tags are handed out in order from zero after reset
        if (commit_tag != (commit_count % (1 << rob_tag_w))) begin
          $display("Mismatch at %0t: commit %0d tag %0d, expected tag %0d", $time,
                   commit_count, commit_tag, commit_count % (1 << rob_tag_w));
          mismatch_count++;
        end
      end
      commit_count++;
    end
  end

  initial begin
    int assert_failures;
    int total_errors;
    rst      <= 1'b1;
    in_valid <= 1'b0;
    in_op    <= ooo_pkg::op_add;
    in_rd    <= '0;
    in_rs1   <= '0;
    in_rs2   <= '0;
    in_imm   <= '0;
    $readmemh("sim/ooo_tests.txt", test_mem);
    count_tests();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < num_tests; i++) begin
      if (!timed_out) begin
        insert_gap();
        present_line(i);
      end
    end
    in_valid <= 1'b0;
    if (!timed_out) begin
      wait_for_commits();
    end
    // quiet stretch to catch a stray commit
    repeat (10) @(posedge clk);
    assert_failures = UUT.u_rob.u_props.failures;
    if (assert_failures > 0) begin
      $display("Error: %0d assertion failures in the ROB checks", assert_failures);
    end
    total_errors = mismatch_count + timeout_count + extra_count + load_errors + assert_failures;
    $display("Errors: %0d mismatches, %0d timeouts, %0d extra commits, %0d load, %0d assertions",
             mismatch_count, timeout_count, extra_count, load_errors, assert_failures);
    if (total_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* sim/ooo_backend_properties.sv */
module ooo_backend_properties #(
  parameter int rob_tag_w = 2
) (
  input logic                 clk,
  input logic                 rst,
  input logic                 alloc_valid,
  input logic                 full,
  input logic                 res_valid,
  input logic [rob_tag_w-1:0] res_tag,
  input logic                 commit_valid,
  input logic [rob_tag_w-1:0] commit_tag
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int depth = 1 << rob_tag_w;

  logic [rob_tag_w-1:0] next_commit_tag;
  // alu results seen per tag, not yet on the commit port
  logic [depth-1:0]     has_result;
  // allocations not yet seen on the commit port
  int                   in_flight;
  int                   live;
  int                   failures = 0;

  // the entry on the commit port was freed one edge earlier
  assign live = in_flight - int'(commit_valid);

  always_ff @(posedge clk) begin
    if (rst) begin
      next_commit_tag <= '0;
      has_result      <= '0;
      in_flight       <= 0;
    end else begin
      if (commit_valid) begin
        next_commit_tag         <= next_commit_tag + 1'b1;
        has_result[commit_tag]  <= 1'b0;
      end
      if (res_valid) begin
        has_result[res_tag] <= 1'b1;
      end
      in_flight <= in_flight + int'(alloc_valid) - int'(commit_valid);
    end
  end

  // retirement walks the buffer one slot at a time
  commit_in_order: assert property (@(posedge clk) disable iff (rst)
    commit_valid |-> (commit_tag == next_commit_tag))
    else begin
      failures++;
      $error("commit tag %0d out of order, expected %0d", commit_tag, next_commit_tag);
    end

  commit_needs_done: assert property (@(posedge clk) disable iff (rst)
    commit_valid |-> has_result[commit_tag])
    else begin
      failures++;
      $error("commit strobe for tag %0d without an alu result", commit_tag);
    end

  no_alloc_when_full: assert property (@(posedge clk) disable iff (rst)
    alloc_valid |-> (live < depth))
    else begin
      failures++;
      $error("allocation accepted while the ROB is full");
    end

  full_flag: assert property (@(posedge clk) disable iff (rst)
    full == (live == depth))
    else begin
      failures++;
      $error("full flag %0b with %0d live entries", full, live);
    end

endmodule

bind reorder_buffer ooo_backend_properties #(.rob_tag_w(rob_tag_w)) u_props (
  .clk, .rst, .alloc_valid, .full, .res_valid, .res_tag,
  .commit_valid, .commit_tag
);

/* design/ooo_backend_top.sv */
module ooo_backend_top #(
  parameter int rob_tag_w = 2
) (
  input  logic                           clk,
  input  logic                           rst,

  input  logic                           in_valid,
  output logic                           in_ready,
  input  ooo_pkg::alu_op_e               in_op,
  input  logic [ooo_pkg::reg_addr_w-1:0] in_rd,
  input  logic [ooo_pkg::reg_addr_w-1:0] in_rs1,
  input  logic [ooo_pkg::reg_addr_w-1:0] in_rs2,
  input  logic [ooo_pkg::xlen-1:0]       in_imm,

  output logic                           commit_valid,
  output logic [ooo_pkg::reg_addr_w-1:0] commit_rd,
  output logic [ooo_pkg::xlen-1:0]       commit_value,
  output logic [rob_tag_w-1:0]           commit_tag
);

  logic [ooo_pkg::reg_addr_w-1:0] issue_rs1_s, issue_rs2_s, issue_rd_s;
  logic [ooo_pkg::xlen-1:0]       issue_rs1_regfile_v, issue_rs2_regfile_v;
  logic                           issue_rs1_regfile_ready, issue_rs2_regfile_ready;
  logic [rob_tag_w-1:0]           issue_rs1_regfile_rob, issue_rs2_regfile_rob;
  logic                           issue_valid;
  logic [rob_tag_w-1:0]           issue_rob;

  logic [rob_tag_w-1:0]           fwd_rs1_tag, fwd_rs2_tag;
  logic                           fwd_rs1_done, fwd_rs2_done;
  logic [ooo_pkg::xlen-1:0]       fwd_rs1_value, fwd_rs2_value;
  logic                           alloc_valid, full;
  logic [ooo_pkg::reg_addr_w-1:0] alloc_rd;
  logic [rob_tag_w-1:0]           alloc_tag;

  logic                           ex_valid, res_valid;
  ooo_pkg::alu_op_e               ex_op;
  logic [ooo_pkg::xlen-1:0]       ex_a, ex_b, res_value;
  logic [rob_tag_w-1:0]           ex_tag, res_tag;

  dispatch_unit #(.rob_tag_w(rob_tag_w)) u_dispatch (.*);

  // commit port doubles as the register file write
  regfile_scoreboard #(.rob_tag_w(rob_tag_w)) u_regfile (
    .clk, .rst,
    .commit_regfile_we(commit_valid), .commit_rd_s(commit_rd),
    .commit_rd_v(commit_value), .commit_rob(commit_tag),
    .issue_valid, .issue_rd_s, .issue_rob, .issue_rs1_s, .issue_rs2_s,
    .issue_rs1_regfile_v, .issue_rs2_regfile_v,
    .issue_rs1_regfile_ready, .issue_rs2_regfile_ready,
    .issue_rs1_regfile_rob, .issue_rs2_regfile_rob
  );

  reorder_buffer #(.rob_tag_w(rob_tag_w)) u_rob (.*);

  int_alu #(.rob_tag_w(rob_tag_w)) u_alu (.*);

endmodule

/* design/int_alu.sv */
module int_alu #(
  parameter int rob_tag_w = 2
) (
  input  logic                     clk,
  input  logic                     rst,

  input  logic                     ex_valid,
  input  ooo_pkg::alu_op_e         ex_op,
  input  logic [ooo_pkg::xlen-1:0] ex_a,
  input  logic [ooo_pkg::xlen-1:0] ex_b,
  input  logic [rob_tag_w-1:0]     ex_tag,

  output logic                     res_valid,
  output logic [rob_tag_w-1:0]     res_tag,
  output logic [ooo_pkg::xlen-1:0] res_value
);

  logic [ooo_pkg::xlen-1:0] alu_out;

  always_comb begin
    case (ex_op)
      // immediate already sits in ex_b
      ooo_pkg::op_add,
      ooo_pkg::op_addi: alu_out = ex_a + ex_b;
      ooo_pkg::op_sub:  alu_out = ex_a - ex_b;
      ooo_pkg::op_and:  alu_out = ex_a & ex_b;
      ooo_pkg::op_or:   alu_out = ex_a | ex_b;
      ooo_pkg::op_xor:  alu_out = ex_a ^ ex_b;
      default:          alu_out = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= ex_valid;
    end
  end

  // one result per cycle, no hold
  always_ff @(posedge clk) begin
    if (ex_valid) begin
      res_tag   <= ex_tag;
      res_value <= alu_out;
    end
  end

endmodule

/* design/dispatch_unit.sv */
module dispatch_unit #(
  parameter int rob_tag_w = 2
) (
  input  logic                           clk,
  input  logic                           rst,

  // decoded instruction port
  input  logic                           in_valid,
  output logic                           in_ready,
  input  ooo_pkg::alu_op_e               in_op,
  input  logic [ooo_pkg::reg_addr_w-1:0] in_rd,
  input  logic [ooo_pkg::reg_addr_w-1:0] in_rs1,
  input  logic [ooo_pkg::reg_addr_w-1:0] in_rs2,
  input  logic [ooo_pkg::xlen-1:0]       in_imm,

  // scoreboard reads
  output logic [ooo_pkg::reg_addr_w-1:0] issue_rs1_s,
  output logic [ooo_pkg::reg_addr_w-1:0] issue_rs2_s,
  input  logic [ooo_pkg::xlen-1:0]       issue_rs1_regfile_v,
  input  logic [ooo_pkg::xlen-1:0]       issue_rs2_regfile_v,
  input  logic                           issue_rs1_regfile_ready,
  input  logic                           issue_rs2_regfile_ready,
  input  logic [rob_tag_w-1:0]           issue_rs1_regfile_rob,
  input  logic [rob_tag_w-1:0]           issue_rs2_regfile_rob,

  // scoreboard booking
  output logic                           issue_valid,
  output logic [ooo_pkg::reg_addr_w-1:0] issue_rd_s,
  output logic [rob_tag_w-1:0]           issue_rob,

  // rob lookups and allocation
  output logic [rob_tag_w-1:0]           fwd_rs1_tag,
  output logic [rob_tag_w-1:0]           fwd_rs2_tag,
  input  logic                           fwd_rs1_done,
  input  logic [ooo_pkg::xlen-1:0]       fwd_rs1_value,
  input  logic                           fwd_rs2_done,
  input  logic [ooo_pkg::xlen-1:0]       fwd_rs2_value,
  output logic                           alloc_valid,
  output logic [ooo_pkg::reg_addr_w-1:0] alloc_rd,
  input  logic [rob_tag_w-1:0]           alloc_tag,
  input  logic                           full,

  // issue toward the alu
  output logic                           ex_valid,
  output ooo_pkg::alu_op_e               ex_op,
  output logic [ooo_pkg::xlen-1:0]       ex_a,
  output logic [ooo_pkg::xlen-1:0]       ex_b,
  output logic [rob_tag_w-1:0]           ex_tag
);

  logic                     uses_rs2;
  logic                     rs1_ok;
  logic                     rs2_ok;
  logic                     accept;
  logic [ooo_pkg::xlen-1:0] op_a;
  logic [ooo_pkg::xlen-1:0] op_b;

  assign issue_rs1_s = in_rs1;
  assign issue_rs2_s = in_rs2;
  // pending tags go straight to the rob for a done check
  assign fwd_rs1_tag = issue_rs1_regfile_rob;
  assign fwd_rs2_tag = issue_rs2_regfile_rob;

  always_comb begin
    uses_rs2 = (in_op != ooo_pkg::op_addi);
    rs1_ok   = issue_rs1_regfile_ready || fwd_rs1_done;
    rs2_ok   = !uses_rs2 || issue_rs2_regfile_ready || fwd_rs2_done;
    op_a     = issue_rs1_regfile_ready ? issue_rs1_regfile_v : fwd_rs1_value;
    if (!uses_rs2) begin
      op_b = in_imm;
    end else begin
      op_b = issue_rs2_regfile_ready ? issue_rs2_regfile_v : fwd_rs2_value;
    end
  end

  // stall on a full rob or an operand still in the alu
  assign in_ready = !full && rs1_ok && rs2_ok;
  assign accept   = in_valid && in_ready;

  assign issue_valid = accept;
  assign issue_rd_s  = in_rd;
  assign issue_rob   = alloc_tag;
  assign alloc_valid = accept;
  assign alloc_rd    = in_rd;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      ex_op  <= in_op;
      ex_a   <= op_a;
      ex_b   <= op_b;
      ex_tag <= alloc_tag;
    end
  end

endmodule

/* design/reorder_buffer.sv */
module reorder_buffer #(
  parameter int rob_tag_w = 2
) (
  input  logic                           clk,
  input  logic                           rst,

  // allocation at the tail
  input  logic                           alloc_valid,
  input  logic [ooo_pkg::reg_addr_w-1:0] alloc_rd,
  output logic [rob_tag_w-1:0]           alloc_tag,
  output logic                           full,

  // alu result
  input  logic                           res_valid,
  input  logic [rob_tag_w-1:0]           res_tag,
  input  logic [ooo_pkg::xlen-1:0]       res_value,

  // operand forwarding lookups
  input  logic [rob_tag_w-1:0]           fwd_rs1_tag,
  input  logic [rob_tag_w-1:0]           fwd_rs2_tag,
  output logic                           fwd_rs1_done,
  output logic [ooo_pkg::xlen-1:0]       fwd_rs1_value,
  output logic                           fwd_rs2_done,
  output logic [ooo_pkg::xlen-1:0]       fwd_rs2_value,

  // in-order retirement
  output logic                           commit_valid,
  output logic [ooo_pkg::reg_addr_w-1:0] commit_rd,
  output logic [ooo_pkg::xlen-1:0]       commit_value,
  output logic [rob_tag_w-1:0]           commit_tag
);

  localparam int depth = 1 << rob_tag_w;

  ooo_pkg::rob_state_e            state [depth];
  logic [ooo_pkg::reg_addr_w-1:0] rd_arr [depth];
  logic [ooo_pkg::xlen-1:0]       val_arr [depth];

  // pointers wrap on their own since depth is a power of two
  logic [rob_tag_w-1:0] head;
  logic [rob_tag_w-1:0] tail;

  logic                     head_done;
  logic [ooo_pkg::xlen-1:0] head_value;

  // entry holds a result, is receiving one now, or is on the commit port
  function automatic logic fwd_hit(input logic [rob_tag_w-1:0] tag);
    fwd_hit = (state[tag] == ooo_pkg::rob_done) ||
              ((state[tag] == ooo_pkg::rob_busy) && res_valid && (res_tag == tag)) ||
              (commit_valid && (commit_tag == tag));
  endfunction

  function automatic logic [ooo_pkg::xlen-1:0] fwd_val(input logic [rob_tag_w-1:0] tag);
    if (state[tag] == ooo_pkg::rob_done) begin
      fwd_val = val_arr[tag];
    end else if (res_valid && (res_tag == tag)) begin
      fwd_val = res_value;
    end else begin
      fwd_val = commit_value;
    end
  endfunction

  assign alloc_tag = tail;
  assign full      = (state[tail] != ooo_pkg::rob_free);

  always_comb begin
    // a result landing on the head retires without an extra cycle
    head_done = (state[head] == ooo_pkg::rob_done) ||
                ((state[head] == ooo_pkg::rob_busy) && res_valid && (res_tag == head));
    head_value = (state[head] == ooo_pkg::rob_done) ? val_arr[head] : res_value;
  end

  always_comb begin
    fwd_rs1_done  = fwd_hit(fwd_rs1_tag);
    fwd_rs1_value = fwd_val(fwd_rs1_tag);
    fwd_rs2_done  = fwd_hit(fwd_rs2_tag);
    fwd_rs2_value = fwd_val(fwd_rs2_tag);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head         <= '0;
      tail         <= '0;
      commit_valid <= 1'b0;
      for (int i = 0; i < depth; i++) begin
        state[i] <= ooo_pkg::rob_free;
      end
    end else begin
      commit_valid <= head_done;
      if (res_valid) begin
        state[res_tag] <= ooo_pkg::rob_done;
      end
      if (alloc_valid) begin
        state[tail] <= ooo_pkg::rob_busy;
        tail        <= tail + 1'b1;
      end
      // retiring frees the slot, even if its result arrived this cycle
      if (head_done) begin
        state[head] <= ooo_pkg::rob_free;
        head        <= head + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_valid) begin
      rd_arr[tail] <= alloc_rd;
    end
    if (res_valid) begin
      val_arr[res_tag] <= res_value;
    end
    if (head_done) begin
      commit_rd    <= rd_arr[head];
      commit_value <= head_value;
      commit_tag   <= head;
    end
  end

endmodule

/* design/regfile_scoreboard.sv */
module regfile_scoreboard #(
  parameter int rob_tag_w = 2
) (
  input  logic                           clk,
  input  logic                           rst,

  // retirement write from the rob
  input  logic                           commit_regfile_we,
  input  logic [ooo_pkg::reg_addr_w-1:0] commit_rd_s,
  input  logic [ooo_pkg::xlen-1:0]       commit_rd_v,
  input  logic [rob_tag_w-1:0]           commit_rob,

  // booking of the destination on dispatch
  input  logic                           issue_valid,
  input  logic [ooo_pkg::reg_addr_w-1:0] issue_rd_s,
  input  logic [rob_tag_w-1:0]           issue_rob,

  // operand reads for the instruction at dispatch
  input  logic [ooo_pkg::reg_addr_w-1:0] issue_rs1_s,
  input  logic [ooo_pkg::reg_addr_w-1:0] issue_rs2_s,
  output logic [ooo_pkg::xlen-1:0]       issue_rs1_regfile_v,
  output logic [ooo_pkg::xlen-1:0]       issue_rs2_regfile_v,
  output logic                           issue_rs1_regfile_ready,
  output logic                           issue_rs2_regfile_ready,
  output logic [rob_tag_w-1:0]           issue_rs1_regfile_rob,
  output logic [rob_tag_w-1:0]           issue_rs2_regfile_rob
);

  localparam int num_regs = 1 << ooo_pkg::reg_addr_w;

  logic [ooo_pkg::xlen-1:0] reg_val [num_regs];
  // youngest in-flight producer of each register
  logic [rob_tag_w-1:0]     reg_tag [num_regs];
  logic                     reg_pending [num_regs];

  logic commit_we_nz;
  logic issue_nz;

  // x0 is hardwired, never written and never booked
  assign commit_we_nz = commit_regfile_we && (commit_rd_s != '0);
  assign issue_nz     = issue_valid && (issue_rd_s != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        reg_val[i]     <= '0;
        reg_tag[i]     <= '0;
        reg_pending[i] <= 1'b0;
      end
    end else begin
      if (commit_we_nz) begin
        reg_val[commit_rd_s] <= commit_rd_v;
        // a younger writer keeps the register pending
        if (reg_pending[commit_rd_s] && (reg_tag[commit_rd_s] == commit_rob)) begin
          reg_pending[commit_rd_s] <= 1'b0;
        end
      end
      // issue comes last so it overrides a same-cycle commit clear
      if (issue_nz) begin
        reg_tag[issue_rd_s]     <= issue_rob;
        reg_pending[issue_rd_s] <= 1'b1;
      end
    end
  end

  always_comb begin
    issue_rs1_regfile_v     = reg_val[issue_rs1_s];
    issue_rs2_regfile_v     = reg_val[issue_rs2_s];
    issue_rs1_regfile_ready = ~reg_pending[issue_rs1_s];
    issue_rs2_regfile_ready = ~reg_pending[issue_rs2_s];
    issue_rs1_regfile_rob   = reg_tag[issue_rs1_s];
    issue_rs2_regfile_rob   = reg_tag[issue_rs2_s];
  end

endmodule

/* design/ooo_pkg.sv */
package ooo_pkg;

  // architectural data width
  localparam int xlen = 32;

  // register index width, 32 architectural registers
  localparam int reg_addr_w = 5;

  // alu operations accepted on the instruction port
  // op_addi takes rs1 and the immediate, all others take rs1 and rs2
  typedef enum logic [2:0] {
    op_add  = 3'd0,
    op_sub  = 3'd1,
    op_and  = 3'd2,
    op_or   = 3'd3,
    op_xor  = 3'd4,
    op_addi = 3'd5
  } alu_op_e;

  // per-entry state of the reorder buffer
  // free: slot unused, may be allocated at the tail
  // busy: allocated, waiting for its alu result
  // done: result written, waiting to retire at the head
  typedef enum logic [1:0] {
    rob_free = 2'd0,
    rob_busy = 2'd1,
    rob_done = 2'd2
  } rob_state_e;

endpackage
